/* Makefile */
# Verilator run of the denoise testbench

VERILATOR ?= verilator
TOP       ?= denoise_tb
FILELIST  ?= denoise.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* denoise.f */
hdl/denoise_pkg.sv
hdl/apb_map_pkg.sv
hdl/apb_regs.sv
hdl/tile_buffer.sv
hdl/denoise_fsm.sv
hdl/pos_counter.sv
hdl/pseudo_median.sv
hdl/denoise_top.sv
sim/denoise_properties.sv
sim/denoise_tb.sv

/* hdl/apb_map_pkg.sv */
package apb_map_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // byte addresses, one 32-bit word per entry
    localparam logic [7:0] pix_base    = 8'h00;  // 25 pixels
    localparam logic [7:0] res_base    = 8'h80;  // 9 results
    localparam logic [7:0] ctrl_addr   = 8'hC0;
    localparam logic [7:0] status_addr = 8'hC4;

    // CTRL
    localparam int ctrl_start_bit = 0;

    // STATUS
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

endpackage

/* hdl/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs
    import denoise_pkg::*;
    import apb_map_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic        busy,
    input  logic        done,
    input  med_result_t result,
    output logic        pix_wr_en,
    output logic [4:0]  pix_wr_idx,
    output pixel_t      pix_wr_data,
    output logic [4:0]  pix_rd_idx,
    input  pixel_t      pix_rd_data,
    output logic        start
);

    logic [5:0]  word;      // address bits 7:2
    logic [5:0]  pix_off;
    logic [5:0]  res_off;
    logic        pix_hit;
    logic        res_hit;
    logic        ctrl_hit;
    logic        stat_hit;
    logic        access;
    logic        err;
    logic        wr_ok;
    logic [3:0]  wr_res_idx;
    logic [31:0] rdata;
    pixel_t      res_q [out_pixels];

    assign word    = apb_req.paddr[7:2];
    assign pix_off = word - pix_base[7:2];  // wraps above the pixel range
    assign res_off = word - res_base[7:2];

    assign pix_hit  = pix_off < 6'(tile_pixels);
    assign res_hit  = res_off < 6'(out_pixels);
    assign ctrl_hit = word == ctrl_addr[7:2];
    assign stat_hit = word == status_addr[7:2];

    assign access = apb_req.psel & apb_req.penable;

    // reject unmapped, read-only targets, and tile or CTRL writes during a run
    always_comb begin
        err = 1'b0;
        if (access) begin
            if (!(pix_hit | res_hit | ctrl_hit | stat_hit))
                err = 1'b1;
            else if (apb_req.pwrite && (res_hit || stat_hit))
                err = 1'b1;
            else if (apb_req.pwrite && busy && (pix_hit || ctrl_hit))
                err = 1'b1;
        end
    end

    assign wr_ok = access & apb_req.pwrite & ~err;

    assign pix_wr_en   = wr_ok & pix_hit;
    assign pix_wr_idx  = pix_off[4:0];
    assign pix_wr_data = apb_req.pwdata[pix_w-1:0];
    assign pix_rd_idx  = pix_off[4:0];

    assign start = wr_ok & ctrl_hit & apb_req.pwdata[ctrl_start_bit];

    assign wr_res_idx = 4'(result.pos.row * out_dim + result.pos.col);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < out_pixels; i++)
                res_q[i] <= '0;
        end else if (result.valid) begin
            res_q[wr_res_idx] <= result.pix;
        end
    end

    always_comb begin
        rdata = '0;
        if (pix_hit)
            rdata[pix_w-1:0] = pix_rd_data;
        else if (res_hit)
            rdata[pix_w-1:0] = res_q[res_off[3:0]];
        else if (stat_hit) begin
            rdata[status_busy_bit] = busy;
            rdata[status_done_bit] = done;
        end
        // CTRL reads back as zero
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;  // no wait states
    assign apb_rsp.pslverr = err;

endmodule

/* hdl/denoise_fsm.sv */
`timescale 1ns/1ps

module denoise_fsm
    import denoise_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        last_pos,
    input  med_result_t result,
    output logic        issue,
    output logic        busy,
    output logic        done
);

    fsm_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_issue;
                        done  <= 1'b0;  // previous results now stale
                    end
                end
                st_issue: begin
                    if (last_pos)
                        state <= st_drain;  // (2,2) goes out this cycle
                end
                st_drain: begin
                    // wait for the last position to leave the pipeline
                    if (result.valid && result.last) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign issue = state == st_issue;  // one position per cycle
    assign busy  = state != st_idle;

endmodule

/* hdl/denoise_pkg.sv */
package denoise_pkg;

    localparam int pix_w       = 8;
    localparam int tile_dim    = 5;   // tile side in pixels
    localparam int win_dim     = 3;
    localparam int out_dim     = 3;   // window positions per side
    localparam int tile_pixels = tile_dim * tile_dim;
    localparam int out_pixels  = out_dim * out_dim;

    typedef logic [pix_w-1:0] pixel_t;

    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
    } win_pos_t;

    // row-major, index 0 is the top-left pixel
    typedef pixel_t [win_dim*win_dim-1:0] window_t;

    typedef struct packed {
        logic     valid;
        logic     last;  // final position of a run
        win_pos_t pos;
        pixel_t   pix;
    } med_result_t;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain
    } fsm_state_t;

    // middle value of three
    function automatic pixel_t median3(pixel_t a, pixel_t b, pixel_t c);
        pixel_t lo;
        pixel_t hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        median3 = (hi < c) ? hi : ((lo > c) ? lo : c);
    endfunction

endpackage

/* hdl/denoise_top.sv */
`timescale 1ns/1ps

module denoise_top
    import denoise_pkg::*;
    import apb_map_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic        pix_wr_en;
    logic [4:0]  pix_wr_idx;
    pixel_t      pix_wr_data;
    logic [4:0]  pix_rd_idx;
    pixel_t      pix_rd_data;
    logic        start;
    logic        issue;
    logic        busy;
    logic        done;
    logic        last_pos;
    win_pos_t    pos;
    window_t     window;
    med_result_t result;

    apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .pix_wr_en   (pix_wr_en),
        .pix_wr_idx  (pix_wr_idx),
        .pix_wr_data (pix_wr_data),
        .pix_rd_idx  (pix_rd_idx),
        .pix_rd_data (pix_rd_data),
        .start       (start)
    );

    tile_buffer u_tile (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_wr_en   (pix_wr_en),
        .pix_wr_idx  (pix_wr_idx),
        .pix_wr_data (pix_wr_data),
        .pix_rd_idx  (pix_rd_idx),
        .pix_rd_data (pix_rd_data),
        .pos         (pos),
        .window      (window)
    );

    denoise_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .last_pos (last_pos),
        .result   (result),
        .issue    (issue),
        .busy     (busy),
        .done     (done)
    );

    pos_counter u_pos (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .pos      (pos),
        .last_pos (last_pos)
    );

    pseudo_median u_med (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (issue),
        .last_in  (last_pos),
        .pos      (pos),
        .window   (window),
        .result   (result)
    );

endmodule

/* hdl/pos_counter.sv */
`timescale 1ns/1ps

module pos_counter
    import denoise_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     issue,
    output win_pos_t pos,
    output logic     last_pos
);

    localparam logic [1:0] max_idx = 2'(out_dim - 1);

    assign last_pos = (pos.row == max_idx) && (pos.col == max_idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (issue) begin
            if (last_pos) begin
                pos <= '0;  // ready for the next run
            end else if (pos.col == max_idx) begin
                pos.col <= '0;
                pos.row <= pos.row + 2'd1;
            end else begin
                pos.col <= pos.col + 2'd1;
            end
        end
    end

endmodule

/* hdl/pseudo_median.sv */
`timescale 1ns/1ps

module pseudo_median
    import denoise_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  logic        last_in,
    input  win_pos_t    pos,
    input  window_t     window,
    output med_result_t result
);

    // stage 1 holds the row medians
    pixel_t   s1_med [win_dim];
    logic     s1_valid;
    logic     s1_last;
    win_pos_t s1_pos;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            s1_last       <= 1'b0;
            result.valid  <= 1'b0;
            result.last   <= 1'b0;
        end else begin
            s1_valid      <= valid_in;
            s1_last       <= last_in & valid_in;
            result.valid  <= s1_valid;
            result.last   <= s1_last;
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        for (int r = 0; r < win_dim; r++)
            s1_med[r] <= median3(window[r*win_dim], window[r*win_dim+1], window[r*win_dim+2]);
        s1_pos     <= pos;
        result.pos <= s1_pos;
        result.pix <= median3(s1_med[0], s1_med[1], s1_med[2]);  // stage 2
    end

endmodule

/* hdl/tile_buffer.sv */
`timescale 1ns/1ps

module tile_buffer
    import denoise_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pix_wr_en,
    input  logic [4:0] pix_wr_idx,
    input  pixel_t     pix_wr_data,
    input  logic [4:0] pix_rd_idx,
    output pixel_t     pix_rd_data,
    input  win_pos_t   pos,
    output window_t    window
);

    pixel_t mem [tile_pixels];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < tile_pixels; i++)
                mem[i] <= '0;
        end else if (pix_wr_en) begin
            mem[pix_wr_idx] <= pix_wr_data;
        end
    end

    // indices past the tile read as zero
    assign pix_rd_data = (pix_rd_idx < 5'(tile_pixels)) ? mem[pix_rd_idx] : '0;

    // 3x3 window with its top-left corner at pos
    always_comb begin
        int idx;
        for (int r = 0; r < win_dim; r++) begin
            for (int c = 0; c < win_dim; c++) begin
                idx = (int'(pos.row) + r) * tile_dim + int'(pos.col) + c;
                window[r*win_dim+c] = mem[idx];
            end
        end
    end

endmodule

/* sim/denoise_properties.sv */
`timescale 1ns/1ps

module denoise_properties
    import denoise_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       start,
    input logic       issue,
    input logic       busy,
    input logic       done,
    input fsm_state_t state
);

    int run_len;  // cycles in the current issue run

    always_ff @(posedge clk) begin
        if (!rst_n)
            run_len <= 0;
        else if (issue)
            run_len <= run_len + 1;
        else
            run_len <= 0;
    end

    issue_ends_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(issue) |-> state == st_drain) else $error("issue run did not end in st_drain");

    busy_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done)) else $error("busy and done high together");

    start_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> busy) else $error("busy not high after start");

    issue_not_long: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> run_len < 9) else $error("issue run longer than 9 cycles");

    issue_run_nine: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(issue) |-> run_len == 9) else $error("issue run not 9 cycles long");

endmodule

bind denoise_fsm denoise_properties u_props (
    .clk(clk), .rst_n(rst_n), .start(start), .issue(issue),
    .busy(busy), .done(done), .state(state)
);

/* sim/denoise_tb.sv */
`timescale 1ns/1ps

module denoise_tb
    import denoise_pkg::*;
    import apb_map_pkg::*;
();

    localparam int poll_limit = 100;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       errors;
    int       tile [tile_pixels];  // last tile sent to the DUT

    denoise_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(string name, int exp, int act);
        $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errors++;
    endtask

    // setup cycle, access cycle, response sampled mid access
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        if (!apb_rsp.pready) begin
            $display("pready low in the access phase at address 0x%0h", addr);
            errors++;
        end
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] rd_ignored;
        apb_xfer(1'b1, addr, data, rd_ignored, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic load_tile(string name);
        logic err;
        for (int i = 0; i < tile_pixels; i++) begin
            apb_write(pix_base + 8'(i * 4), tile[i], err);
            if (err) report_mismatch({name, " pixel pslverr"}, 0, 1);
        end
    endtask

    task automatic start_run(string name);
        logic err;
        apb_write(ctrl_addr, 32'h1, err);
        if (err) report_mismatch({name, " start pslverr"}, 0, 1);
    endtask

    task automatic wait_done(string name);
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st[status_done_bit] && polls < poll_limit) begin
            apb_read(status_addr, st, err);
            polls++;
        end
        if (!st[status_done_bit]) begin
            $display("%s: done not seen after %0d STATUS polls", name, polls);
            errors++;
        end
    endtask

    function automatic int mid3(int a, int b, int c);
        int lo;
        int hi;
        lo = a;
        hi = a;
        if (b < lo) lo = b;
        if (c < lo) lo = c;
        if (b > hi) hi = b;
        if (c > hi) hi = c;
        return a + b + c - lo - hi;  // neither smallest nor largest
    endfunction

    // reference median of the three row medians of each 3x3 window
    task automatic check_results(string name);
        int          rm [win_dim];
        int          exp;
        int          base;
        logic [31:0] d;
        logic        err;
        for (int r = 0; r < out_dim; r++) begin
            for (int c = 0; c < out_dim; c++) begin
                for (int i = 0; i < win_dim; i++) begin
                    base  = (r + i) * tile_dim + c;
                    rm[i] = mid3(tile[base], tile[base+1], tile[base+2]);
                end
                exp = mid3(rm[0], rm[1], rm[2]);
                apb_read(res_base + 8'((r * out_dim + c) * 4), d, err);
                if (d != exp) report_mismatch(name, exp, d);
            end
        end
    endtask

    task automatic random_tile();
        for (int i = 0; i < tile_pixels; i++) begin
            tile[i] = $urandom_range(255);
            if ($urandom_range(3) == 0)
                tile[i] = $urandom_range(1) ? 255 : 0;  // salt or pepper
        end
    endtask

    task automatic reset_values();
        logic [31:0] d;
        logic        err;
        apb_read(status_addr, d, err);
        if (d != 0) report_mismatch("reset status", 0, d);
        for (int i = 0; i < out_pixels; i++) begin
            apb_read(res_base + 8'(i * 4), d, err);
            if (d != 0) report_mismatch("reset result", 0, d);
        end
        for (int i = 0; i < tile_pixels; i++) begin
            apb_read(pix_base + 8'(i * 4), d, err);
            if (d != 0) report_mismatch("reset pixel", 0, d);
        end
    endtask

    task automatic pixel_readback();
        logic [31:0] d;
        logic        err;
        for (int i = 0; i < tile_pixels; i++)
            tile[i] = i * 10 + 3;  // all distinct
        load_tile("readback");
        for (int i = 0; i < tile_pixels; i++) begin
            apb_read(pix_base + 8'(i * 4), d, err);
            if (err) report_mismatch("readback pslverr", 0, 1);
            if (d != tile[i]) report_mismatch("readback", tile[i], d);
        end
    endtask

    task automatic flat_tile();
        logic [31:0] d;
        logic        err;
        for (int i = 0; i < tile_pixels; i++)
            tile[i] = 'h5A;
        load_tile("flat");
        start_run("flat");
        wait_done("flat");
        apb_read(status_addr, d, err);
        if (d != 32'h2) report_mismatch("flat status", 2, d);  // done without busy
        for (int i = 0; i < out_pixels; i++) begin
            apb_read(res_base + 8'(i * 4), d, err);
            if (d != 'h5A) report_mismatch("flat", 'h5A, d);
        end
    endtask

    task automatic impulse_noise();
        random_tile();
        load_tile("impulse");
        start_run("impulse");
        wait_done("impulse");
        check_results("impulse");
    endtask

    task automatic rejected_accesses();
        logic [31:0] d;
        logic        err;
        apb_read(8'h64, d, err);  // one past the last pixel
        if (!err) report_mismatch("unmapped pslverr", 1, 0);
        apb_write(status_addr, 32'h3, err);
        if (!err) report_mismatch("status write pslverr", 1, 0);
        start_run("reject");
        apb_write(pix_base + 8'd12, tile[3] ^ 255, err);
        if (!err) report_mismatch("busy pixel pslverr", 1, 0);
        apb_write(ctrl_addr, 32'h1, err);
        if (!err) report_mismatch("busy start pslverr", 1, 0);
        wait_done("reject");
        apb_read(pix_base + 8'd12, d, err);
        if (d != tile[3]) report_mismatch("busy pixel kept", tile[3], d);
    endtask

    task automatic back_to_back_runs();
        logic [31:0] d;
        logic        err;
        random_tile();
        load_tile("run a");
        start_run("run a");
        wait_done("run a");
        check_results("run a");
        random_tile();
        load_tile("run b");
        start_run("run b");
        apb_read(status_addr, d, err);
        if (d != 32'h1) report_mismatch("run b status", 1, d);  // busy with done cleared
        wait_done("run b");
        check_results("run b");
    endtask

    initial begin
        errors  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        void'($urandom(32'h7737_20ec));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_values();
        pixel_readback();
        flat_tile();
        impulse_noise();
        rejected_accesses();
        back_to_back_runs();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
